// ==== verilog/oflow_core_pkg.sv ====
/*
 * oflow core package
 * tracker-wide widths plus the score-board load and result structs
 */
package oflow_core_pkg;

	// --------------------------------------------------
	// widths
	// --------------------------------------------------
	localparam int SCORE_LEN = 12;                  // PE match score
	localparam int ID_LEN = 11;                     // bbox id, 2048 ids
	localparam int ROW_LEN = 3;                     // score-board row index
	localparam int PE_LEN = 2;                      // candidate slot index
	localparam int NUM_OF_BBOX_IN_FRAME_WIDTH = 4;  // bbox counts, up to 8 rows

	localparam int NUM_ROWS = 2 ** ROW_LEN;  // current bboxes held
	localparam int NUM_PES = 2 ** PE_LEN;    // candidates per row

	// --------------------------------------------------
	// score-board structs
	// --------------------------------------------------
	// one candidate slot write, sampled on the edge where we is high
	typedef struct packed {
		logic                 we;
		logic [ROW_LEN-1:0]   row;
		logic [PE_LEN-1:0]    pe;
		logic [SCORE_LEN-1:0] score;
		logic [ID_LEN-1:0]    id;
	} sb_load_t;

	// resolved view of one row
	typedef struct packed {
		logic              assigned;  // pointer bit, row has a final id
		logic [ID_LEN-1:0] id;
	} sb_result_t;

endpackage

// ==== verilog/oflow_cr_pkg.sv ====
/*
 * conflict-resolve package
 * FSM states, LUT geometry and entry layout, conflict limit
 */
package oflow_cr_pkg;

	// LUT geometry, one entry per bbox id
	localparam int DATA_WIDTH_LUT = 16;
	localparam int ADDR_WIDTH_LUT = oflow_core_pkg::ID_LEN;

	// failed claims tolerated per run before fallback to fresh ids
	localparam int MAX_CONFLICTS_TH = 6;
	localparam int CONFLICT_CNT_LEN = $clog2(MAX_CONFLICTS_TH + 1);

	// --------------------------------------------------
	// FSM states
	// --------------------------------------------------
	typedef enum logic [3:0] {
		IDLE,
		CLEAR,     // per-run init
		SCAN,      // look for next unassigned row
		READ_SB,   // fetch candidate from score board
		READ_LUT,  // LUT read issued
		DECIDE,    // LUT data valid, claim or lose
		EVICT,     // kick out weaker holder
		NEW_ID,    // take id from new-bbox counter
		WRITE_ID,  // commit final id to score board
		DONE
	} cr_state_t;

	// who holds an id, fills the 16-bit LUT word
	typedef struct packed {
		logic [oflow_core_pkg::ROW_LEN-1:0]   holder_row;
		logic [oflow_core_pkg::SCORE_LEN-1:0] holder_score;
		logic                                 spare;
	} lut_entry_t;

endpackage

// ==== verilog/oflow_cr_lut.sv ====
/*
 * conflict-resolve LUT
 * behavioral 2048x16 dual-port model, write port plus registered read port
 * sharing one address
 */
`timescale 1ns/100ps

module oflow_cr_lut (
	input  logic                                    clk,
	input  logic [oflow_cr_pkg::ADDR_WIDTH_LUT-1:0] address_lut,
	input  logic [oflow_cr_pkg::DATA_WIDTH_LUT-1:0] data_in_lut,
	input  logic                                    we_lut,
	input  logic                                    csb,  // read enable
	output logic [oflow_cr_pkg::DATA_WIDTH_LUT-1:0] data_out_lut_for_fsm
);

	logic [oflow_cr_pkg::DATA_WIDTH_LUT-1:0] mem [2 ** oflow_cr_pkg::ADDR_WIDTH_LUT];

	// write wins, read output holds while writing or idle
	always_ff @(posedge clk) begin
		if (we_lut) begin
			mem[address_lut] <= data_in_lut;
		end else if (csb) begin
			data_out_lut_for_fsm <= mem[address_lut];  // valid one clock later
		end
	end

endmodule

// ==== verilog/oflow_score_board.sv ====
/*
 * score board
 * 8x4 candidate slots with per-row pointer, assigned bit and resolved id
 * combinational read paths for the CR FSM and for results
 */
`timescale 1ns/100ps

module oflow_score_board (
	input  logic                                   clk,
	input  logic                                   reset_N,
	input  oflow_core_pkg::sb_load_t               sb_load,
	// FSM read side
	input  logic [oflow_core_pkg::ROW_LEN-1:0]     row_sel_from_cr,
	input  logic [oflow_core_pkg::PE_LEN-1:0]      pe_sel_from_cr,
	output logic [oflow_core_pkg::SCORE_LEN-1:0]   score_to_cr,
	output logic [oflow_core_pkg::ID_LEN-1:0]      id_to_cr,
	output logic [oflow_core_pkg::PE_LEN:0]        pointer_of_row,  // {assigned, pe}
	// FSM write side
	input  logic [oflow_core_pkg::ROW_LEN-1:0]     row_to_change,
	input  logic [oflow_core_pkg::PE_LEN-1:0]      pe_to_change,
	input  logic                                   data_to_score_board_from_cr_pointer,
	input  logic                                   write_to_pointer,
	input  logic [oflow_core_pkg::ID_LEN-1:0]      data_to_score_board_from_cr_id,
	input  logic                                   write_to_id,
	// result side
	input  logic [oflow_core_pkg::ROW_LEN-1:0]     result_row,
	output oflow_core_pkg::sb_result_t             result
);

	logic [oflow_core_pkg::SCORE_LEN-1:0] score_mem [oflow_core_pkg::NUM_ROWS][oflow_core_pkg::NUM_PES];
	logic [oflow_core_pkg::ID_LEN-1:0]    id_mem [oflow_core_pkg::NUM_ROWS][oflow_core_pkg::NUM_PES];
	logic [oflow_core_pkg::ID_LEN-1:0]    res_id [oflow_core_pkg::NUM_ROWS];  // final ids
	logic [oflow_core_pkg::PE_LEN-1:0]    pointer [oflow_core_pkg::NUM_ROWS];  // current candidate
	logic [oflow_core_pkg::NUM_ROWS-1:0]  assigned;

	// --------------------------------------------------
	// storage
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (sb_load.we) begin
			score_mem[sb_load.row][sb_load.pe] <= sb_load.score;
			id_mem[sb_load.row][sb_load.pe] <= sb_load.id;
		end
		if (write_to_id)
			res_id[row_to_change] <= data_to_score_board_from_cr_id;
	end

	// pointer and assigned bit, a load restarts the row
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			pointer <= '{default: '0};
			assigned <= '0;
		end else begin
			if (sb_load.we) begin
				pointer[sb_load.row] <= '0;
				assigned[sb_load.row] <= 1'b0;
			end
			if (write_to_pointer) begin
				pointer[row_to_change] <= pe_to_change;
				assigned[row_to_change] <= data_to_score_board_from_cr_pointer;
			end
		end
	end

	// --------------------------------------------------
	// read paths
	// --------------------------------------------------
	assign score_to_cr = score_mem[row_sel_from_cr][pe_sel_from_cr];
	assign id_to_cr = id_mem[row_sel_from_cr][pe_sel_from_cr];
	assign pointer_of_row = {assigned[row_sel_from_cr], pointer[row_sel_from_cr]};
	assign result = oflow_core_pkg::sb_result_t'{assigned: assigned[result_row],
		id: res_id[result_row]};

	// loads only happen while CR idles, never on the row CR is updating
	a_no_load_cr_clash: assert property (@(posedge clk) disable iff (!reset_N)
		sb_load.we && (write_to_pointer || write_to_id) |-> sb_load.row != row_to_change);

endmodule

// ==== verilog/oflow_conflict_resolve_fsm.sv ====
/*
 * conflict-resolve FSM
 * assigns every current row a final id by claim, evict and fallback,
 * tracks conflicts and the new-bbox id counter
 */
`timescale 1ns/100ps

module oflow_conflict_resolve_fsm (
	input  logic                                              clk,
	input  logic                                              reset_N,
	input  logic                                              start_cr,
	output logic                                              done_cr,
	// configuration, sampled at start
	input  logic [oflow_core_pkg::SCORE_LEN-1:0]              score_th_for_new_bbox,
	input  logic                                              initial_counter_for_new_bbox,
	input  logic [oflow_core_pkg::NUM_OF_BBOX_IN_FRAME_WIDTH-1:0] total_bboxes_first_frame,
	input  logic [oflow_core_pkg::NUM_OF_BBOX_IN_FRAME_WIDTH-1:0] rows_in_frame,
	// LUT
	output logic [oflow_cr_pkg::ADDR_WIDTH_LUT-1:0]           address_lut,
	output logic [oflow_cr_pkg::DATA_WIDTH_LUT-1:0]           data_in_lut,
	output logic                                              we_lut,
	output logic                                              csb,
	input  logic [oflow_cr_pkg::DATA_WIDTH_LUT-1:0]           data_out_lut_for_fsm,
	// claimed flags
	output logic [oflow_cr_pkg::ADDR_WIDTH_LUT-1:0]           address_flag,
	output logic                                              data_in_flag,
	input  logic                                              data_out_flag,
	// score board
	input  logic [oflow_core_pkg::SCORE_LEN-1:0]              score_to_cr,
	input  logic [oflow_core_pkg::ID_LEN-1:0]                 id_to_cr,
	input  logic [oflow_core_pkg::PE_LEN:0]                   pointer_of_row,
	output logic [oflow_core_pkg::ROW_LEN-1:0]                row_sel_from_cr,
	output logic [oflow_core_pkg::PE_LEN-1:0]                 pe_sel_from_cr,
	output logic [oflow_core_pkg::ROW_LEN-1:0]                row_to_change,
	output logic [oflow_core_pkg::PE_LEN-1:0]                 pe_to_change,
	output logic                                              data_to_score_board_from_cr_pointer,
	output logic                                              write_to_pointer,
	output logic [oflow_core_pkg::ID_LEN-1:0]                 data_to_score_board_from_cr_id,
	output logic                                              write_to_id,
	output logic                                              conflict_counter_th
);

	oflow_cr_pkg::cr_state_t state, next_state;
	oflow_cr_pkg::lut_entry_t entry;  // LUT word seen as holder info

	logic [oflow_core_pkg::NUM_OF_BBOX_IN_FRAME_WIDTH-1:0] cur_row, rows_q;
	logic [oflow_core_pkg::SCORE_LEN-1:0] score_th_q, cand_score;
	logic [oflow_core_pkg::ID_LEN-1:0] cand_id, final_id, new_id_cnt;
	logic [oflow_cr_pkg::CONFLICT_CNT_LEN-1:0] conflict_cnt;
	logic pass_changed;  // pass found an unassigned row
	logic [oflow_core_pkg::PE_LEN-1:0] ptr_pe;
	logic row_assigned, holder_wins, th_next, last_try;

	assign entry = data_out_lut_for_fsm;
	assign ptr_pe = pointer_of_row[oflow_core_pkg::PE_LEN-1:0];
	assign row_assigned = pointer_of_row[oflow_core_pkg::PE_LEN];
	assign pe_sel_from_cr = ptr_pe;
	assign holder_wins = entry.holder_score >= cand_score;  // ties stay with holder
	assign th_next = 32'(conflict_cnt) + 1 >= oflow_cr_pkg::MAX_CONFLICTS_TH;
	assign last_try = (ptr_pe == '1) || th_next;  // out of candidates or limit hit

	// LUT and flag always address the candidate id
	assign address_lut = cand_id;
	assign address_flag = cand_id;
	assign data_in_lut = oflow_cr_pkg::lut_entry_t'{holder_row: cur_row[oflow_core_pkg::ROW_LEN-1:0],
		holder_score: cand_score, spare: 1'b0};
	assign data_in_flag = 1'b1;
	assign data_to_score_board_from_cr_id = final_id;
	assign done_cr = state == oflow_cr_pkg::DONE;

	// --------------------------------------------------
	// next state
	// --------------------------------------------------
	always_comb begin
		next_state = state;
		case (state)
			oflow_cr_pkg::IDLE:     if (start_cr) next_state = oflow_cr_pkg::CLEAR;
			oflow_cr_pkg::CLEAR:    next_state = oflow_cr_pkg::SCAN;
			oflow_cr_pkg::SCAN: begin
				if (cur_row >= rows_q)
					next_state = pass_changed ? oflow_cr_pkg::SCAN : oflow_cr_pkg::DONE;
				else if (!row_assigned)  // limit reached, skip matching
					next_state = conflict_counter_th ? oflow_cr_pkg::NEW_ID : oflow_cr_pkg::READ_SB;
			end
			oflow_cr_pkg::READ_SB:  // sorted slots, rest is below threshold too
				next_state = (score_to_cr < score_th_q) ? oflow_cr_pkg::NEW_ID : oflow_cr_pkg::READ_LUT;
			oflow_cr_pkg::READ_LUT: next_state = oflow_cr_pkg::DECIDE;
			oflow_cr_pkg::DECIDE: begin
				if (!data_out_flag) next_state = oflow_cr_pkg::WRITE_ID;  // free id
				else if (!holder_wins) next_state = oflow_cr_pkg::EVICT;
				else next_state = last_try ? oflow_cr_pkg::NEW_ID : oflow_cr_pkg::READ_SB;
			end
			oflow_cr_pkg::EVICT,
			oflow_cr_pkg::NEW_ID:   next_state = oflow_cr_pkg::WRITE_ID;
			oflow_cr_pkg::WRITE_ID: next_state = oflow_cr_pkg::SCAN;
			oflow_cr_pkg::DONE:     next_state = oflow_cr_pkg::IDLE;
			default:                next_state = oflow_cr_pkg::IDLE;
		endcase
	end

	// --------------------------------------------------
	// strobes to LUT and score board
	// --------------------------------------------------
	always_comb begin
		row_sel_from_cr = cur_row[oflow_core_pkg::ROW_LEN-1:0];
		row_to_change = cur_row[oflow_core_pkg::ROW_LEN-1:0];
		pe_to_change = ptr_pe;
		data_to_score_board_from_cr_pointer = 1'b0;
		write_to_pointer = 1'b0;
		write_to_id = 1'b0;
		we_lut = 1'b0;
		csb = 1'b0;
		case (state)
			oflow_cr_pkg::READ_LUT: csb = 1'b1;
			oflow_cr_pkg::DECIDE: begin
				if (!data_out_flag) begin
					we_lut = 1'b1;  // claim
				end else if (holder_wins && !last_try) begin
					write_to_pointer = 1'b1;  // proposer moves on
					pe_to_change = ptr_pe + 1'b1;
				end
			end
			oflow_cr_pkg::EVICT: begin
				// LUT out still holds the holder, no read since DECIDE
				row_sel_from_cr = entry.holder_row;
				row_to_change = entry.holder_row;
				write_to_pointer = 1'b1;
				pe_to_change = (ptr_pe == '1) ? ptr_pe : ptr_pe + 1'b1;  // last slot retried
				we_lut = 1'b1;  // winner takes the entry
			end
			oflow_cr_pkg::WRITE_ID: begin
				write_to_pointer = 1'b1;
				data_to_score_board_from_cr_pointer = 1'b1;
				write_to_id = 1'b1;
			end
			default: ;
		endcase
	end

	// --------------------------------------------------
	// control regs
	// --------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= oflow_cr_pkg::IDLE;
			cur_row <= '0;
			pass_changed <= 1'b0;
			conflict_cnt <= '0;
			conflict_counter_th <= 1'b0;
			new_id_cnt <= '0;
		end else begin
			state <= next_state;
			case (state)
				oflow_cr_pkg::IDLE: if (start_cr) begin
					conflict_cnt <= '0;
					conflict_counter_th <= 1'b0;
					if (initial_counter_for_new_bbox)  // else continue from last run
						new_id_cnt <= oflow_core_pkg::ID_LEN'(total_bboxes_first_frame);
				end
				oflow_cr_pkg::CLEAR: begin
					cur_row <= '0;
					pass_changed <= 1'b0;
				end
				oflow_cr_pkg::SCAN: begin
					if (cur_row >= rows_q) begin  // end of pass
						cur_row <= '0;
						pass_changed <= 1'b0;
					end else if (row_assigned) begin
						cur_row <= cur_row + 1'b1;
					end else begin
						pass_changed <= 1'b1;
					end
				end
				oflow_cr_pkg::DECIDE: if (data_out_flag) begin  // id taken, one conflict
					conflict_cnt <= conflict_cnt + 1'b1;
					if (th_next) conflict_counter_th <= 1'b1;
				end
				oflow_cr_pkg::NEW_ID:   new_id_cnt <= new_id_cnt + 1'b1;
				oflow_cr_pkg::WRITE_ID: cur_row <= cur_row + 1'b1;
				default: ;
			endcase
		end
	end

	// config and candidate payload
	always_ff @(posedge clk) begin
		if (state == oflow_cr_pkg::IDLE && start_cr) begin
			score_th_q <= score_th_for_new_bbox;
			rows_q <= rows_in_frame;
		end
		if (state == oflow_cr_pkg::READ_SB) begin
			cand_score <= score_to_cr;
			cand_id <= id_to_cr;
		end
		if (state == oflow_cr_pkg::DECIDE) final_id <= cand_id;
		if (state == oflow_cr_pkg::NEW_ID) final_id <= new_id_cnt;
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	a_start_idle: assert property (@(posedge clk) disable iff (!reset_N)
		start_cr |-> state == oflow_cr_pkg::IDLE);
	a_done_pulse: assert property (@(posedge clk) disable iff (!reset_N)
		done_cr |=> !done_cr);
	// final id only goes to a row that holds none yet
	a_id_with_ptr: assert property (@(posedge clk) disable iff (!reset_N)
		write_to_id |-> write_to_pointer && data_to_score_board_from_cr_pointer && !row_assigned);

endmodule

// ==== verilog/oflow_conflict_resolve.sv ====
/*
 * conflict resolve
 * claimed-flag store, CR FSM and id LUT
 */
`timescale 1ns/100ps

module oflow_conflict_resolve (
	input  logic                                              clk,
	input  logic                                              reset_N,
	input  logic                                              start_cr,
	output logic                                              done_cr,
	input  logic [oflow_core_pkg::SCORE_LEN-1:0]              score_th_for_new_bbox,
	input  logic                                              initial_counter_for_new_bbox,
	input  logic [oflow_core_pkg::NUM_OF_BBOX_IN_FRAME_WIDTH-1:0] total_bboxes_first_frame,
	input  logic [oflow_core_pkg::NUM_OF_BBOX_IN_FRAME_WIDTH-1:0] rows_in_frame,
	// score board
	input  logic [oflow_core_pkg::SCORE_LEN-1:0]              score_to_cr,
	input  logic [oflow_core_pkg::ID_LEN-1:0]                 id_to_cr,
	input  logic [oflow_core_pkg::PE_LEN:0]                   pointer_of_row,
	output logic [oflow_core_pkg::ROW_LEN-1:0]                row_sel_from_cr,
	output logic [oflow_core_pkg::PE_LEN-1:0]                 pe_sel_from_cr,
	output logic [oflow_core_pkg::ROW_LEN-1:0]                row_to_change,
	output logic [oflow_core_pkg::PE_LEN-1:0]                 pe_to_change,
	output logic                                              data_to_score_board_from_cr_pointer,
	output logic                                              write_to_pointer,
	output logic [oflow_core_pkg::ID_LEN-1:0]                 data_to_score_board_from_cr_id,
	output logic                                              write_to_id,
	output logic                                              conflict_counter_th
);

	logic [oflow_cr_pkg::DATA_WIDTH_LUT-1:0] data_out_lut_for_fsm;
	logic [oflow_cr_pkg::DATA_WIDTH_LUT-1:0] data_in_lut;
	logic [oflow_cr_pkg::ADDR_WIDTH_LUT-1:0] address_lut;
	logic we_lut, csb;

	logic [2 ** oflow_cr_pkg::ADDR_WIDTH_LUT-1:0] flag;  // one claimed bit per id
	logic [oflow_cr_pkg::ADDR_WIDTH_LUT-1:0] address_flag;
	logic data_in_flag, data_out_flag;

	// --------------------------------------------------
	// claimed flags
	// --------------------------------------------------
	assign data_out_flag = flag[address_flag];

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			flag <= '0;
		else if (start_cr)  // new frame, nothing claimed
			flag <= '0;
		else if (we_lut)    // flag follows its LUT entry
			flag[address_flag] <= data_in_flag;
	end

	// --------------------------------------------------
	// FSM and LUT
	// --------------------------------------------------
	oflow_conflict_resolve_fsm oflow_conflict_resolve_fsm (
		.clk, .reset_N, .start_cr, .done_cr,
		.score_th_for_new_bbox, .initial_counter_for_new_bbox,
		.total_bboxes_first_frame, .rows_in_frame,
		.address_lut, .data_in_lut, .we_lut, .csb, .data_out_lut_for_fsm,
		.address_flag, .data_in_flag, .data_out_flag,
		.score_to_cr, .id_to_cr, .pointer_of_row,
		.row_sel_from_cr, .pe_sel_from_cr, .row_to_change, .pe_to_change,
		.data_to_score_board_from_cr_pointer, .write_to_pointer,
		.data_to_score_board_from_cr_id, .write_to_id,
		.conflict_counter_th
	);

	oflow_cr_lut oflow_cr_lut (
		.clk,
		.address_lut,
		.data_in_lut,
		.we_lut,
		.csb,
		.data_out_lut_for_fsm
	);

endmodule

// ==== verilog/oflow_cr_top.sv ====
/*
 * conflict-resolve top
 * score board plus conflict resolve, load and result ports outside
 */
`timescale 1ns/100ps

module oflow_cr_top (
	input  logic                                              clk,
	input  logic                                              reset_N,
	input  logic                                              start_cr,
	output logic                                              done_cr,
	input  logic [oflow_core_pkg::SCORE_LEN-1:0]              score_th_for_new_bbox,
	input  logic                                              initial_counter_for_new_bbox,
	input  logic [oflow_core_pkg::NUM_OF_BBOX_IN_FRAME_WIDTH-1:0] total_bboxes_first_frame,
	input  logic [oflow_core_pkg::NUM_OF_BBOX_IN_FRAME_WIDTH-1:0] rows_in_frame,
	input  oflow_core_pkg::sb_load_t                          sb_load,
	input  logic [oflow_core_pkg::ROW_LEN-1:0]                result_row,
	output oflow_core_pkg::sb_result_t                        result,
	output logic                                              conflict_counter_th
);

	// CR to score board
	logic [oflow_core_pkg::SCORE_LEN-1:0] score_to_cr;
	logic [oflow_core_pkg::ID_LEN-1:0]    id_to_cr;
	logic [oflow_core_pkg::PE_LEN:0]      pointer_of_row;
	logic [oflow_core_pkg::ROW_LEN-1:0]   row_sel_from_cr, row_to_change;
	logic [oflow_core_pkg::PE_LEN-1:0]    pe_sel_from_cr, pe_to_change;
	logic                                 data_to_score_board_from_cr_pointer, write_to_pointer;
	logic [oflow_core_pkg::ID_LEN-1:0]    data_to_score_board_from_cr_id;
	logic                                 write_to_id;

	oflow_score_board oflow_score_board (
		.clk, .reset_N, .sb_load,
		.row_sel_from_cr, .pe_sel_from_cr, .score_to_cr, .id_to_cr, .pointer_of_row,
		.row_to_change, .pe_to_change,
		.data_to_score_board_from_cr_pointer, .write_to_pointer,
		.data_to_score_board_from_cr_id, .write_to_id,
		.result_row, .result
	);

	oflow_conflict_resolve oflow_conflict_resolve (
		.clk, .reset_N, .start_cr, .done_cr,
		.score_th_for_new_bbox, .initial_counter_for_new_bbox,
		.total_bboxes_first_frame, .rows_in_frame,
		.score_to_cr, .id_to_cr, .pointer_of_row,
		.row_sel_from_cr, .pe_sel_from_cr, .row_to_change, .pe_to_change,
		.data_to_score_board_from_cr_pointer, .write_to_pointer,
		.data_to_score_board_from_cr_id, .write_to_id,
		.conflict_counter_th
	);

endmodule

// ==== verif/oflow_cr_tb.sv ====
/*
 * conflict-resolve testbench
 * table of score-board scenarios, each loaded, resolved and read back row by row
 */
`timescale 1ns/100ps

module oflow_cr_tb;

	localparam int NUM_SCEN = 5;
	localparam int TIMEOUT_CYCLES = 5000;
	localparam int CNT_W = oflow_core_pkg::NUM_OF_BBOX_IN_FRAME_WIDTH;

	logic clk;
	logic reset_N;
	logic start_cr;
	logic done_cr;
	logic [oflow_core_pkg::SCORE_LEN-1:0] score_th_for_new_bbox;
	logic initial_counter_for_new_bbox;
	logic [CNT_W-1:0] total_bboxes_first_frame;
	logic [CNT_W-1:0] rows_in_frame;
	oflow_core_pkg::sb_load_t sb_load;
	logic [oflow_core_pkg::ROW_LEN-1:0] result_row;
	oflow_core_pkg::sb_result_t result;
	logic conflict_counter_th;

	// --------------------------------------------------
	// scenario table, score 0 = filler slot
	// --------------------------------------------------
	int tab_rows [NUM_SCEN];
	logic [oflow_core_pkg::SCORE_LEN-1:0] tab_th [NUM_SCEN];
	logic [CNT_W-1:0] tab_total [NUM_SCEN];
	logic tab_init [NUM_SCEN];
	logic tab_exp_th [NUM_SCEN];  // conflict limit hit
	logic [oflow_core_pkg::SCORE_LEN-1:0] tab_score [NUM_SCEN][oflow_core_pkg::NUM_ROWS][4];
	logic [oflow_core_pkg::ID_LEN-1:0] tab_id [NUM_SCEN][oflow_core_pkg::NUM_ROWS][4];
	logic [oflow_core_pkg::ID_LEN-1:0] tab_exp_id [NUM_SCEN][oflow_core_pkg::NUM_ROWS];

	int errors;
	int checks;
	int seed;
	bit timed_out;

	oflow_cr_top oflow_cr_top_i (
		.clk, .reset_N, .start_cr, .done_cr,
		.score_th_for_new_bbox, .initial_counter_for_new_bbox,
		.total_bboxes_first_frame, .rows_in_frame,
		.sb_load, .result_row, .result, .conflict_counter_th
	);

	always #50 clk = ~clk;  // 100 ns period

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
		end
	endtask

	// new scenario, all slots filler until rows are set
	task automatic set_cfg(input int s, input int rows, input int th, input int total,
		input bit init, input bit exp_th);
		int r;
		int p;
		tab_rows[s] = rows;
		tab_th[s] = th[oflow_core_pkg::SCORE_LEN-1:0];
		tab_total[s] = total[CNT_W-1:0];
		tab_init[s] = init;
		tab_exp_th[s] = exp_th;
		for (r = 0; r < oflow_core_pkg::NUM_ROWS; r++) begin
			tab_exp_id[s][r] = '0;
			for (p = 0; p < oflow_core_pkg::NUM_PES; p++) begin
				tab_score[s][r][p] = '0;
				tab_id[s][r][p] = '0;
			end
		end
	endtask

	// expected id, then score/id per PE slot
	task automatic set_row(input int s, input int r, input int exp_id,
		input int sc0, input int id0, input int sc1, input int id1,
		input int sc2, input int id2, input int sc3, input int id3);
		int sc [4];
		int id [4];
		int p;
		sc = '{sc0, sc1, sc2, sc3};
		id = '{id0, id1, id2, id3};
		tab_exp_id[s][r] = exp_id[oflow_core_pkg::ID_LEN-1:0];
		for (p = 0; p < oflow_core_pkg::NUM_PES; p++) begin
			tab_score[s][r][p] = sc[p][oflow_core_pkg::SCORE_LEN-1:0];
			tab_id[s][r][p] = id[p][oflow_core_pkg::ID_LEN-1:0];
		end
	endtask

	task automatic fill_table();
		// distinct ids, two rows with nothing usable
		set_cfg(0, 5, 64, 10, 1'b1, 1'b0);
		set_row(0, 0, 3, 500, 3, 0, 0, 0, 0, 0, 0);
		set_row(0, 1, 7, 400, 7, 0, 0, 0, 0, 0, 0);
		set_row(0, 2, 1, 300, 1, 0, 0, 0, 0, 0, 0);
		set_row(0, 3, 10, 0, 0, 0, 0, 0, 0, 0, 0);
		set_row(0, 4, 11, 0, 0, 0, 0, 0, 0, 0, 0);
		// counter carries on from run 0, total ignored
		set_cfg(1, 3, 64, 3, 1'b0, 1'b0);
		set_row(1, 0, 12, 0, 0, 0, 0, 0, 0, 0, 0);
		set_row(1, 1, 2, 80, 2, 0, 0, 0, 0, 0, 0);
		set_row(1, 2, 13, 40, 5, 0, 0, 0, 0, 0, 0);
		// eviction, tie kept by holder, chained eviction of row 3
		set_cfg(2, 4, 64, 12, 1'b1, 1'b0);
		set_row(2, 0, 9, 300, 5, 200, 6, 150, 9, 0, 0);
		set_row(2, 1, 5, 500, 5, 100, 8, 0, 0, 0, 0);
		set_row(2, 2, 6, 200, 6, 120, 7, 0, 0, 0, 0);
		set_row(2, 3, 4, 120, 9, 90, 4, 0, 0, 0, 0);
		// row 4 loses all four, row 5 under threshold
		set_cfg(3, 6, 200, 4, 1'b1, 1'b0);
		set_row(3, 0, 0, 900, 0, 0, 0, 0, 0, 0, 0);
		set_row(3, 1, 1, 900, 1, 0, 0, 0, 0, 0, 0);
		set_row(3, 2, 2, 900, 2, 0, 0, 0, 0, 0, 0);
		set_row(3, 3, 3, 900, 3, 0, 0, 0, 0, 0, 0);
		set_row(3, 4, 4, 500, 0, 500, 1, 500, 2, 500, 3);
		set_row(3, 5, 5, 150, 30, 0, 0, 0, 0, 0, 0);
		// everyone wants id 7, limit reached in row 4
		set_cfg(4, 6, 64, 8, 1'b1, 1'b1);
		set_row(4, 0, 7, 500, 7, 450, 6, 0, 0, 0, 0);
		set_row(4, 1, 6, 400, 7, 350, 6, 0, 0, 0, 0);
		set_row(4, 2, 8, 300, 7, 250, 6, 0, 0, 0, 0);
		set_row(4, 3, 9, 200, 7, 150, 6, 0, 0, 0, 0);
		set_row(4, 4, 10, 100, 7, 90, 6, 0, 0, 0, 0);
		set_row(4, 5, 11, 80, 7, 70, 6, 66, 3, 0, 0);  // slot 2 free but skipped
	endtask

	// --------------------------------------------------
	// drive and check
	// --------------------------------------------------
	task automatic load_scenario(input int s);
		int r;
		int p;
		int rnd;
		for (r = 0; r < oflow_core_pkg::NUM_ROWS; r++) begin
			for (p = 0; p < oflow_core_pkg::NUM_PES; p++) begin
				@(posedge clk);
				#1;
				sb_load.we = 1'b1;
				sb_load.row = r[oflow_core_pkg::ROW_LEN-1:0];
				sb_load.pe = p[oflow_core_pkg::PE_LEN-1:0];
				sb_load.score = tab_score[s][r][p];
				sb_load.id = tab_id[s][r][p];
				if (tab_score[s][r][p] == '0) begin
					rnd = $random(seed);
					sb_load.score = rnd[oflow_core_pkg::SCORE_LEN-1:0] & 12'h03f;  // < 64
					rnd = $random(seed);
					sb_load.id = rnd[oflow_core_pkg::ID_LEN-1:0];
				end
			end
		end
		@(posedge clk);
		#1;
		sb_load.we = 1'b0;
	endtask

	// result is combinational, sampled mid-cycle
	task automatic read_row(input int r);
		@(posedge clk);
		#1;
		result_row = r[oflow_core_pkg::ROW_LEN-1:0];
		@(negedge clk);
	endtask

	task automatic check_after_reset();
		int r;
		@(negedge clk);
		check_value("done_cr", 32'(done_cr), 32'd0);
		check_value("conflict_counter_th", 32'(conflict_counter_th), 32'd0);
		for (r = 0; r < oflow_core_pkg::NUM_ROWS; r++) begin
			read_row(r);
			check_value($sformatf("result.assigned row %0d", r), 32'(result.assigned), 32'd0);
		end
	endtask

	task automatic resolve(input int s);
		int cycles;
		int r;
		@(posedge clk);
		#1;
		score_th_for_new_bbox = tab_th[s];
		initial_counter_for_new_bbox = tab_init[s];
		total_bboxes_first_frame = tab_total[s];
		rows_in_frame = tab_rows[s][CNT_W-1:0];
		start_cr = 1'b1;
		@(posedge clk);
		#1;
		start_cr = 1'b0;
		cycles = 0;
		@(negedge clk);
		while (!done_cr && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		if (!done_cr) begin
			$display("timeout: scenario %0d got no done_cr in %0d cycles", s, TIMEOUT_CYCLES);
			errors++;
			timed_out = 1'b1;
		end else begin
			check_value("conflict_counter_th", 32'(conflict_counter_th), 32'(tab_exp_th[s]));
			for (r = 0; r < oflow_core_pkg::NUM_ROWS; r++) begin
				read_row(r);
				check_value($sformatf("result.assigned row %0d", r), 32'(result.assigned),
					32'(r < tab_rows[s]));
				if (r < tab_rows[s])
					check_value($sformatf("result.id row %0d", r), 32'(result.id),
						32'(tab_exp_id[s][r]));
			end
		end
	endtask

	initial begin
		errors = 0;
		checks = 0;
		seed = 32'h2bb3_b248;
		timed_out = 1'b0;
		clk = 1'b0;
		reset_N = 1'b0;
		start_cr = 1'b0;
		score_th_for_new_bbox = '0;
		initial_counter_for_new_bbox = 1'b0;
		total_bboxes_first_frame = '0;
		rows_in_frame = '0;
		sb_load = '0;
		result_row = '0;
		fill_table();
		repeat (10) @(posedge clk);
		#1;
		reset_N = 1'b1;
		check_after_reset();
		for (int s = 0; s < NUM_SCEN && !timed_out; s++) begin
			load_scenario(s);
			resolve(s);
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== build.f ====
verilog/oflow_core_pkg.sv
verilog/oflow_cr_pkg.sv
verilog/oflow_cr_lut.sv
verilog/oflow_score_board.sv
verilog/oflow_conflict_resolve_fsm.sv
verilog/oflow_conflict_resolve.sv
verilog/oflow_cr_top.sv
verif/oflow_cr_tb.sv

// ==== Makefile ====
# Verilator build and run of the conflict-resolve testbench

.PHONY: all run clean

all: run

obj_dir/Voflow_cr_tb: build.f $(wildcard verilog/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --assert --top-module oflow_cr_tb -f build.f -o Voflow_cr_tb

# pass only when the pass line shows up in the output
run: obj_dir/Voflow_cr_tb
	./obj_dir/Voflow_cr_tb | awk '{ print } /^Test OK$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
